// File: Bender.yml
package:
  name: trigio

export_include_dirs:
  - hw

sources:
  - files:
      - hw/trigioPkg.sv
      - hw/trigCfgIf.sv
      - hw/trigStatIf.sv
      - hw/hostRegs.sv
      - hw/coincLogic.sv
      - hw/runCounters.sv
      - hw/frontOutMux.sv
      - hw/trigioTop.sv
  - target: test
    files:
      - tests/tbClock.sv
      - tests/trigioTb.sv

// File: hw/coincLogic.sv
`timescale 1ns/1ps
`include "trigio_settings.svh"

module coincLogic
(
   input  logic               proc_clk,
   input  logic               rstN,
   input  trigioPkg::frontT   frontA,
   input  trigioPkg::trigBusT trigIn,
   trigCfgIf.coinc            cfg,
   trigStatIf.coinc           stat
);
   import trigioPkg::*;

   // lines that take part in multiplicity
   frontT      multA;
   trigBusT    multT;

   // first stage nibble counts
   logic [2:0] partA [4];
   logic [2:0] partT [8];

   // extra stage for the wide bus
   logic [4:0] halfLo;
   logic [4:0] halfHi;

   // ones in a nibble
   function automatic logic [2:0] count4(logic [3:0] n);
      return {2'b00, n[0]} + {2'b00, n[1]} + {2'b00, n[2]} + {2'b00, n[3]};
   endfunction

   assign multA = frontA & cfg.aMultMask;
   assign multT = trigIn & cfg.tMultMask;

   // ***********************************************************************
   // multiplicity pipeline
   // ***********************************************************************
   // front A sum after two edges, trigger bus sum after three
   always_ff @(posedge proc_clk)
   begin
      if (!rstN)
      begin
         partA     <= '{default: '0};
         partT     <= '{default: '0};
         halfLo    <= '0;
         halfHi    <= '0;
         stat.sumA <= '0;
         stat.sumT <= '0;
      end
      else
      begin
         for (int i = 0; i < 4; i++)
         begin
            partA[i] <= count4(multA[4*i +: 4]);
         end
         for (int i = 0; i < 8; i++)
         begin
            partT[i] <= count4(multT[4*i +: 4]);
         end
         stat.sumA <= {5'd0, partA[0]} + {5'd0, partA[1]} + {5'd0, partA[2]}
                      + {5'd0, partA[3]};
         halfLo    <= {2'b00, partT[0]} + {2'b00, partT[1]} + {2'b00, partT[2]}
                      + {2'b00, partT[3]};
         halfHi    <= {2'b00, partT[4]} + {2'b00, partT[5]} + {2'b00, partT[6]}
                      + {2'b00, partT[7]};
         stat.sumT <= {3'd0, halfLo} + {3'd0, halfHi};
      end
   end

   // ***********************************************************************
   // result flags
   // ***********************************************************************
   always_comb
   begin
      stat.coincResult = '0;
      // pattern match follows the inputs directly
      stat.coincResult[`COINC_BIT_A] = (frontA & cfg.aCoincMask) == cfg.aCoincPat;
      stat.coincResult[`COINC_BIT_T] = (trigIn & cfg.tCoincMask) == cfg.tCoincPat;
      // at or above threshold
      stat.coincResult[`MULT_BIT_A]  = stat.sumA >= cfg.aThresh;
      stat.coincResult[`MULT_BIT_T]  = stat.sumT >= cfg.tThresh;
   end

   // sums stay within the line count of their group
   sumARange: assert property (@(posedge proc_clk) disable iff (!rstN)
      stat.sumA <= 8'd16);
   sumTRange: assert property (@(posedge proc_clk) disable iff (!rstN)
      stat.sumT <= 8'd32);

endmodule

// File: hw/frontOutMux.sv
`timescale 1ns/1ps
`include "trigio_settings.svh"

module frontOutMux
(
   input  logic               proc_clk,
   input  logic               rstN,
   input  trigioPkg::trigBusT trigIn,
   input  trigioPkg::coincT   coincResult,
   input  logic               tickBit,
   trigCfgIf.mux              cfg,
   output trigioPkg::frontT   frontBOut
);
   // ***********************************************************************
   // front panel B source select
   // ***********************************************************************
   // upper half of the backplane bus feeds front panel B
   always_ff @(posedge proc_clk)
   begin
      if (!rstN)
      begin
         frontBOut <= '0;
      end
      else
      begin
         case (cfg.bOutSel)
            `OUTSEL_PASS:  frontBOut <= trigIn[31:16];
            `OUTSEL_CMASK: frontBOut <= trigIn[31:16] & cfg.tCoincMask[31:16];
            `OUTSEL_MMASK: frontBOut <= trigIn[31:16] & cfg.tMultMask[31:16];
            // result flags fanned out to every line
            `OUTSEL_COINC: frontBOut <= {16{coincResult[`COINC_BIT_T]}};
            `OUTSEL_MULT:  frontBOut <= {16{coincResult[`MULT_BIT_T]}};
            // slow square wave for cabling checks
            `OUTSEL_TICK:  frontBOut <= {16{tickBit}};
            default:       frontBOut <= '0;
         endcase
      end
   end

endmodule

// File: hw/hostRegs.sv
`timescale 1ns/1ps
`include "trigio_settings.svh"

module hostRegs
(
   input  logic                proc_clk,
   input  logic                rstN,
   input  trigioPkg::wordIdxT  hostAddr,
   input  trigioPkg::byteStrbT hostWrStrb,
   input  trigioPkg::wordT     hostWrData,
   input  logic                hostRdEn,
   output trigioPkg::wordT     hostRdData,
   input  trigioPkg::frontT    frontA,
   input  trigioPkg::trigBusT  trigIn,
   trigCfgIf.driver            cfg,
   trigStatIf.host             stat
);
   import trigioPkg::*;

   // configuration words as last written by the host
   wordT  csrReg;
   wordT  blockReg;
   wordT  aCMaskReg;
   wordT  tCMaskReg;
   wordT  aMMaskReg;
   wordT  tMMaskReg;
   wordT  aCPatReg;
   wordT  tCPatReg;
   wordT  aThreshReg;
   wordT  tThreshReg;
   wordT  outSelReg;

   blockT blockSel;
   wordT  cfgWord;
   wordT  resWord;

   // replace only the strobed bytes
   function automatic wordT mergeBytes(wordT oldWord, wordT newWord, byteStrbT strb);
      wordT merged;
      merged = oldWord;
      for (int i = 0; i < 4; i++)
      begin
         if (strb[i])
         begin
            merged[8*i +: 8] = newWord[8*i +: 8];
         end
      end
      return merged;
   endfunction

   // ***********************************************************************
   // write decode
   // ***********************************************************************
   always_ff @(posedge proc_clk)
   begin
      if (!rstN)
      begin
         csrReg         <= '0;
         blockReg       <= '0;
         aCMaskReg      <= '0;
         tCMaskReg      <= '0;
         aMMaskReg      <= '0;
         tMMaskReg      <= '0;
         aCPatReg       <= '0;
         tCPatReg       <= '0;
         aThreshReg     <= '0;
         tThreshReg     <= '0;
         outSelReg      <= '0;
         cfg.counterClr <= 1'b0;
      end
      else
      begin
         // clear pulse follows any write cycle to the clear word
         cfg.counterClr <= (|hostWrStrb) && (hostAddr == `ADDR_CLEAR);
         if (|hostWrStrb)
         begin
            case (hostAddr)
               `ADDR_CSR:      csrReg     <= mergeBytes(csrReg, hostWrData, hostWrStrb);
               `ADDR_BLOCK:    blockReg   <= mergeBytes(blockReg, hostWrData, hostWrStrb);
               `ADDR_A_CMASK:  aCMaskReg  <= mergeBytes(aCMaskReg, hostWrData, hostWrStrb);
               `ADDR_T_CMASK:  tCMaskReg  <= mergeBytes(tCMaskReg, hostWrData, hostWrStrb);
               `ADDR_A_MMASK:  aMMaskReg  <= mergeBytes(aMMaskReg, hostWrData, hostWrStrb);
               `ADDR_T_MMASK:  tMMaskReg  <= mergeBytes(tMMaskReg, hostWrData, hostWrStrb);
               `ADDR_A_CPAT:   aCPatReg   <= mergeBytes(aCPatReg, hostWrData, hostWrStrb);
               `ADDR_T_CPAT:   tCPatReg   <= mergeBytes(tCPatReg, hostWrData, hostWrStrb);
               `ADDR_A_THRESH: aThreshReg <= mergeBytes(aThreshReg, hostWrData, hostWrStrb);
               `ADDR_T_THRESH: tThreshReg <= mergeBytes(tThreshReg, hostWrData, hostWrStrb);
               `ADDR_B_OUTSEL: outSelReg  <= mergeBytes(outSelReg, hostWrData, hostWrStrb);
               default:        ;
            endcase
         end
      end
   end

   // fields seen by the processing side
   assign cfg.aCoincMask = aCMaskReg[15:0];
   assign cfg.tCoincMask = tCMaskReg;
   assign cfg.aMultMask  = aMMaskReg[15:0];
   assign cfg.tMultMask  = tMMaskReg;
   assign cfg.aCoincPat  = aCPatReg[15:0];
   assign cfg.tCoincPat  = tCPatReg;
   assign cfg.aThresh    = aThreshReg[7:0];
   assign cfg.tThresh    = tThreshReg[7:0];
   assign cfg.bOutSel    = outSelReg[7:0];
   assign blockSel       = blockReg[1:0];

   // ***********************************************************************
   // read multiplexer
   // ***********************************************************************
   // configuration readback
   always_comb
   begin
      case (hostAddr)
         `ADDR_CSR:      cfgWord = csrReg;
         `ADDR_BLOCK:    cfgWord = blockReg;
         `ADDR_A_CMASK:  cfgWord = aCMaskReg;
         `ADDR_T_CMASK:  cfgWord = tCMaskReg;
         `ADDR_A_MMASK:  cfgWord = aMMaskReg;
         `ADDR_T_MMASK:  cfgWord = tMMaskReg;
         `ADDR_A_CPAT:   cfgWord = aCPatReg;
         `ADDR_T_CPAT:   cfgWord = tCPatReg;
         `ADDR_A_THRESH: cfgWord = aThreshReg;
         `ADDR_T_THRESH: cfgWord = tThreshReg;
         `ADDR_B_OUTSEL: cfgWord = outSelReg;
         default:        cfgWord = '0;
      endcase
   end

   // result map
   always_comb
   begin
      case (hostAddr)
         // csr bit 0 is run enable
         `RES_CSR:        resWord = {31'd0, csrReg[0]};
         `RES_REV:        resWord = `TRIGIO_REVISION;
         `RES_COINC:      resWord = {16'd0, stat.coincResult};
         `RES_NUMTRIG_LO: resWord = stat.numTrig[31:0];
         `RES_NUMTRIG_HI: resWord = stat.numTrig[63:32];
         `RES_TICKS_LO:   resWord = stat.runTicks[31:0];
         `RES_TICKS_HI:   resWord = stat.runTicks[63:32];
         // raw and coincidence masked inputs
         `RES_A_IN:       resWord = {16'd0, frontA};
         `RES_T_IN:       resWord = trigIn;
         `RES_A_MASKED:   resWord = {16'd0, frontA & aCMaskReg[15:0]};
         `RES_T_MASKED:   resWord = trigIn & tCMaskReg;
         `RES_SUM_A:      resWord = {24'd0, stat.sumA};
         `RES_SUM_T:      resWord = {24'd0, stat.sumT};
         default:         resWord = '0;
      endcase
   end

   // registered read, held until the next strobe
   always_ff @(posedge proc_clk)
   begin
      if (!rstN)
      begin
         hostRdData <= '0;
      end
      else if (hostRdEn)
      begin
         case (blockSel)
            `BLOCK_CFG: hostRdData <= cfgWord;
            `BLOCK_RES: hostRdData <= resWord;
            default:    hostRdData <= `UNMAPPED_READ;
         endcase
      end
   end

   // host never sees undefined bits from any block
   rdDataKnown: assert property (@(posedge proc_clk) disable iff (!rstN)
      hostRdEn |=> !$isunknown(hostRdData));

endmodule

// File: hw/runCounters.sv
`timescale 1ns/1ps

module runCounters
(
   input  logic               proc_clk,
   input  logic               rstN,
   input  trigioPkg::trigBusT trigIn,
   trigCfgIf.counter          cfg,
   trigStatIf.counter         stat
);
   // two stage chain on trigger line 7
   logic trigSyncA;
   logic trigSyncB;
   logic trigEdge;

   always_ff @(posedge proc_clk)
   begin
      if (!rstN)
      begin
         trigSyncA <= 1'b0;
         trigSyncB <= 1'b0;
      end
      else
      begin
         trigSyncA <= trigIn[7];
         trigSyncB <= trigSyncA;
      end
   end

   // one cycle per rising edge
   assign trigEdge = trigSyncA & ~trigSyncB;

   // ***********************************************************************
   // counters
   // ***********************************************************************
   // run time in proc_clk ticks
   always_ff @(posedge proc_clk)
   begin
      if (!rstN || cfg.counterClr)
      begin
         stat.runTicks <= '0;
      end
      else
      begin
         stat.runTicks <= stat.runTicks + 64'd1;
      end
   end

   // trigger count
   always_ff @(posedge proc_clk)
   begin
      if (!rstN || cfg.counterClr)
      begin
         stat.numTrig <= '0;
      end
      else if (trigEdge)
      begin
         stat.numTrig <= stat.numTrig + 64'd1;
      end
   end

   // at most one trigger per cycle outside a clear
   numTrigStep: assert property (@(posedge proc_clk) disable iff (!rstN)
      !cfg.counterClr |=> (stat.numTrig - $past(stat.numTrig)) <= 64'd1);

endmodule

// File: hw/trigCfgIf.sv
`timescale 1ns/1ps

interface trigCfgIf;
   import trigioPkg::*;

   // coincidence masks and patterns
   frontT   aCoincMask;
   trigBusT tCoincMask;
   frontT   aCoincPat;
   trigBusT tCoincPat;

   // multiplicity masks and thresholds
   frontT   aMultMask;
   trigBusT tMultMask;
   threshT  aThresh;
   threshT  tThresh;

   // front panel B source
   outSelT  bOutSel;

   // one cycle pulse after host write to clear address
   logic    counterClr;

   modport driver (output aCoincMask, tCoincMask, aCoincPat, tCoincPat,
                   output aMultMask, tMultMask, aThresh, tThresh,
                   output bOutSel, counterClr);
   modport coinc (input aCoincMask, tCoincMask, aCoincPat, tCoincPat,
                  input aMultMask, tMultMask, aThresh, tThresh);
   modport mux (input tCoincMask, tMultMask, bOutSel);
   modport counter (input counterClr);

endinterface

// File: hw/trigStatIf.sv
`timescale 1ns/1ps

interface trigStatIf;
   import trigioPkg::*;

   // from coincidence logic
   coincT   coincResult;
   multSumT sumA;
   multSumT sumT;

   // from run counters
   countT   numTrig;
   countT   runTicks;

   // coincidence side
   modport coinc (output coincResult, sumA, sumT);

   // counter side
   modport counter (output numTrig, runTicks);

   // register bank readback
   modport host (input coincResult, sumA, sumT, numTrig, runTicks);

endinterface

// File: hw/trigioPkg.sv
package trigioPkg;

   // host register bus
   typedef logic [31:0] wordT;
   typedef logic [3:0]  byteStrbT;
   // word index taken from host address bits 10..2
   typedef logic [8:0]  wordIdxT;

   // trigger inputs
   typedef logic [15:0] frontT;
   typedef logic [31:0] trigBusT;

   // multiplicity
   typedef logic [7:0]  multSumT;
   typedef logic [7:0]  threshT;

   // front panel B source select
   typedef logic [7:0]  outSelT;

   // read block selector
   typedef logic [1:0]  blockT;

   // coincidence and multiplicity flags
   typedef logic [15:0] coincT;

   // run and trigger counters
   typedef logic [63:0] countT;

endpackage

// File: hw/trigioTop.sv
`timescale 1ns/1ps
`include "trigio_settings.svh"

module trigioTop
(
   input  logic                proc_clk,
   input  logic                rstN,
   // host register bus
   input  trigioPkg::wordIdxT  hostAddr,
   input  trigioPkg::byteStrbT hostWrStrb,
   input  trigioPkg::wordT     hostWrData,
   input  logic                hostRdEn,
   output trigioPkg::wordT     hostRdData,
   // trigger lines
   input  trigioPkg::frontT    frontA,
   input  trigioPkg::trigBusT  trigIn,
   output trigioPkg::frontT    frontBOut
);
   // ***********************************************************************
   // internal buses
   // ***********************************************************************
   trigCfgIf  cfgBus ();
   trigStatIf statBus ();

   // configuration and readback
   hostRegs u_hostRegs (
      .proc_clk   (proc_clk),
      .rstN       (rstN),
      .hostAddr   (hostAddr),
      .hostWrStrb (hostWrStrb),
      .hostWrData (hostWrData),
      .hostRdEn   (hostRdEn),
      .hostRdData (hostRdData),
      .frontA     (frontA),
      .trigIn     (trigIn),
      .cfg        (cfgBus.driver),
      .stat       (statBus.host)
   );

   // coincidence and multiplicity
   coincLogic u_coincLogic (
      .proc_clk (proc_clk),
      .rstN     (rstN),
      .frontA   (frontA),
      .trigIn   (trigIn),
      .cfg      (cfgBus.coinc),
      .stat     (statBus.coinc)
   );

   // run time and trigger counts
   runCounters u_runCounters (
      .proc_clk (proc_clk),
      .rstN     (rstN),
      .trigIn   (trigIn),
      .cfg      (cfgBus.counter),
      .stat     (statBus.counter)
   );

   // front panel B driver
   frontOutMux u_frontOutMux (
      .proc_clk    (proc_clk),
      .rstN        (rstN),
      .trigIn      (trigIn),
      .coincResult (statBus.coincResult),
      .tickBit     (statBus.runTicks[`TICK_BIT]),
      .cfg         (cfgBus.mux),
      .frontBOut   (frontBOut)
   );

endmodule

// File: hw/trigio_settings.svh
`ifndef TRIGIO_SETTINGS_SVH
`define TRIGIO_SETTINGS_SVH

// revision word returned in the result block
`define TRIGIO_REVISION 32'hB100_0002

// configuration block word addresses
`define ADDR_CSR      9'h000
`define ADDR_BLOCK    9'h003
`define ADDR_CLEAR    9'h009
`define ADDR_A_CMASK  9'h108
`define ADDR_T_CMASK  9'h10B
`define ADDR_A_MMASK  9'h110
`define ADDR_T_MMASK  9'h113
`define ADDR_A_CPAT   9'h118
`define ADDR_T_CPAT   9'h11B
`define ADDR_A_THRESH 9'h120
`define ADDR_T_THRESH 9'h123
`define ADDR_B_OUTSEL 9'h129

// result block word addresses
`define RES_CSR        9'h000
`define RES_REV        9'h001
`define RES_COINC      9'h005
`define RES_NUMTRIG_LO 9'h00A
`define RES_NUMTRIG_HI 9'h00B
`define RES_TICKS_LO   9'h00C
`define RES_TICKS_HI   9'h00D
`define RES_A_IN       9'h100
`define RES_T_IN       9'h103
`define RES_A_MASKED   9'h108
`define RES_T_MASKED   9'h10B
`define RES_SUM_A      9'h110
`define RES_SUM_T      9'h113

// read block codes
`define BLOCK_CFG     2'd0
`define BLOCK_RES     2'd1
`define UNMAPPED_READ 32'h0000_0123

// front panel B source select codes
`define OUTSEL_PASS  8'd0
`define OUTSEL_CMASK 8'd1
`define OUTSEL_MMASK 8'd2
`define OUTSEL_COINC 8'd3
`define OUTSEL_MULT  8'd4
`define OUTSEL_TICK  8'd5

// bit positions in the coincidence result word
`define COINC_BIT_A 0
`define COINC_BIT_T 3
`define MULT_BIT_A  8
`define MULT_BIT_T  11

// run tick bit used as slow test signal
`define TICK_BIT 8

`endif

// File: src.f
+incdir+hw
hw/trigioPkg.sv
hw/trigCfgIf.sv
hw/trigStatIf.sv
hw/hostRegs.sv
hw/coincLogic.sv
hw/runCounters.sv
hw/frontOutMux.sv
hw/trigioTop.sv
tests/tbClock.sv
tests/trigioTb.sv

// File: tests/tbClock.sv
`timescale 1ns/1ps

module tbClock
(
   output logic proc_clk,
   output logic rstN
);
   // 4 ns period
   initial
   begin
      proc_clk = 1'b0;
      forever #2 proc_clk = ~proc_clk;
   end

   // reset low for eight rising edges, released on an edge
   initial
   begin
      rstN = 1'b0;
      repeat (8) @(posedge proc_clk);
      rstN <= 1'b1;
   end

endmodule

// File: tests/trigioTb.sv
`timescale 1ns/1ps
`include "trigio_settings.svh"

module trigioTb;
   import trigioPkg::*;

   // 40 us in 4 ns cycles leaves about five times the run length
   localparam int watchdogCycles = 10000;

   logic    proc_clk;
   logic    rstN;
   wordIdxT hostAddr;
   byteStrbT hostWrStrb;
   wordT    hostWrData;
   logic    hostRdEn;
   wordT    hostRdData;
   frontT   frontA;
   trigBusT trigIn;
   frontT   frontBOut;

   int mismatchCount = 0;
   int otherErrors = 0;
   int cycleCount = 0;

   // expected register contents tracked on every host write
   wordT shadow [512] = '{default: '0};

   tbClock u_tbClock (
      .proc_clk (proc_clk),
      .rstN     (rstN)
   );

   trigioTop u_trigioTop (
      .proc_clk   (proc_clk),
      .rstN       (rstN),
      .hostAddr   (hostAddr),
      .hostWrStrb (hostWrStrb),
      .hostWrData (hostWrData),
      .hostRdEn   (hostRdEn),
      .hostRdData (hostRdData),
      .frontA     (frontA),
      .trigIn     (trigIn),
      .frontBOut  (frontBOut)
   );

   always @(posedge proc_clk)
   begin
      cycleCount <= cycleCount + 1;
   end

   // *************************************************************************
   // compare tasks
   // *************************************************************************
   task automatic checkWord(input string name, input wordT expVal, input wordT actVal);
      if (expVal !== actVal)
      begin
         mismatchCount++;
         $display("Mismatch %s: expected 0x%08h actual 0x%08h", name, expVal, actVal);
      end
   endtask

   task automatic checkFront(input string name, input frontT expVal, input frontT actVal);
      if (expVal !== actVal)
      begin
         mismatchCount++;
         $display("Mismatch %s: expected 0x%04h actual 0x%04h", name, expVal, actVal);
      end
   endtask

   task automatic checkCount(input string name, input countT expVal, input countT actVal);
      if (expVal !== actVal)
      begin
         mismatchCount++;
         $display("Mismatch %s: expected %0d actual %0d", name, expVal, actVal);
      end
   endtask

   // *************************************************************************
   // host bus
   // *************************************************************************
   task automatic waitCycles(input int n);
      repeat (n) @(posedge proc_clk);
   endtask

   task automatic hostWrite(input wordIdxT addr, input byteStrbT strb, input wordT data);
      wordT keep;
      @(posedge proc_clk);
      hostAddr   <= addr;
      hostWrStrb <= strb;
      hostWrData <= data;
      @(posedge proc_clk);
      hostWrStrb <= '0;
      // each strobe bit owns one byte lane
      keep = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
      shadow[addr] = (shadow[addr] & ~keep) | (data & keep);
   endtask

   // data registered on the strobe edge and sampled at the following low phase
   task automatic hostRead(input wordIdxT addr, output wordT data);
      @(posedge proc_clk);
      hostAddr <= addr;
      hostRdEn <= 1'b1;
      @(posedge proc_clk);
      hostRdEn <= 1'b0;
      @(negedge proc_clk);
      data = hostRdData;
   endtask

   task automatic setBlock(input blockT blk);
      hostWrite(`ADDR_BLOCK, 4'hF, {30'd0, blk});
   endtask

   task automatic driveInputs(input frontT a, input trigBusT t);
      @(posedge proc_clk);
      frontA <= a;
      trigIn <= t;
   endtask

   // *************************************************************************
   // directed tests
   // *************************************************************************
   task automatic identityTest();
      wordT rd;
      hostRead(`ADDR_CSR, rd);
      checkWord("identity csr after reset", '0, rd);
      setBlock(`BLOCK_RES);
      hostRead(`RES_REV, rd);
      checkWord("identity revision", `TRIGIO_REVISION, rd);
      // run enable set and then cleared
      hostWrite(`ADDR_CSR, 4'h1, 32'h1);
      hostRead(`RES_CSR, rd);
      checkWord("identity run enable on", 32'h1, rd);
      hostWrite(`ADDR_CSR, 4'h1, 32'h0);
      hostRead(`RES_CSR, rd);
      checkWord("identity run enable off", 32'h0, rd);
      setBlock(`BLOCK_CFG);
   endtask

   task automatic cfgReadbackTest();
      wordIdxT mapped [10];
      wordT    rd;
      mapped = '{`ADDR_CSR, `ADDR_A_CMASK, `ADDR_T_CMASK, `ADDR_A_MMASK, `ADDR_T_MMASK,
                 `ADDR_A_CPAT, `ADDR_T_CPAT, `ADDR_A_THRESH, `ADDR_T_THRESH, `ADDR_B_OUTSEL};
      // two rounds of partial byte writes per word
      for (int pass = 0; pass < 2; pass++)
      begin
         for (int i = 0; i < 10; i++)
         begin
            hostWrite(mapped[i], byteStrbT'($urandom % 16), $urandom);
         end
      end
      for (int i = 0; i < 10; i++)
      begin
         hostRead(mapped[i], rd);
         checkWord("cfg readback", shadow[mapped[i]], rd);
      end
      // holes in the map
      hostRead(9'h002, rd);
      checkWord("cfg unmapped 0x002", '0, rd);
      hostRead(`ADDR_CLEAR, rd);
      checkWord("cfg unmapped clear", '0, rd);
      hostRead(9'h1FF, rd);
      checkWord("cfg unmapped 0x1ff", '0, rd);
      setBlock(2'd2);
      hostRead(`ADDR_CSR, rd);
      checkWord("cfg block 2 marker", `UNMAPPED_READ, rd);
      setBlock(`BLOCK_CFG);
   endtask

   task automatic coincTest(input int rounds);
      frontT   a;
      frontT   aMask;
      frontT   aPat;
      trigBusT t;
      trigBusT tMask;
      trigBusT tPat;
      logic    expA;
      logic    expT;
      wordT    rd;
      setBlock(`BLOCK_RES);
      for (int i = 0; i < rounds; i++)
      begin
         a     = $urandom;
         t     = $urandom;
         aMask = $urandom;
         tMask = $urandom;
         // matching pattern on some rounds so both outcomes occur
         aPat  = (i % 2 == 0) ? (a & aMask) : frontT'($urandom);
         tPat  = (i % 4 < 2) ? (t & tMask) : trigBusT'($urandom);
         hostWrite(`ADDR_A_CMASK, 4'hF, {16'd0, aMask});
         hostWrite(`ADDR_T_CMASK, 4'hF, tMask);
         hostWrite(`ADDR_A_CPAT, 4'hF, {16'd0, aPat});
         hostWrite(`ADDR_T_CPAT, 4'hF, tPat);
         driveInputs(a, t);
         hostRead(`RES_A_IN, rd);
         checkWord("coinc raw A", {16'd0, a}, rd);
         hostRead(`RES_T_IN, rd);
         checkWord("coinc raw T", t, rd);
         hostRead(`RES_A_MASKED, rd);
         checkWord("coinc masked A", {16'd0, a & aMask}, rd);
         hostRead(`RES_T_MASKED, rd);
         checkWord("coinc masked T", t & tMask, rd);
         expA = ((a & aMask) == aPat);
         expT = ((t & tMask) == tPat);
         hostRead(`RES_COINC, rd);
         checkWord("coinc flags", {28'd0, expT, 2'b00, expA}, rd & 32'h9);
      end
   endtask

   task automatic multTest(input int rounds);
      frontT   a;
      frontT   aMask;
      trigBusT t;
      trigBusT tMask;
      threshT  aTh;
      threshT  tTh;
      int      sumA;
      int      sumT;
      wordT    rd;
      for (int i = 0; i < rounds; i++)
      begin
         a     = $urandom;
         t     = $urandom;
         aMask = $urandom;
         tMask = $urandom;
         aTh   = threshT'($urandom % 18);
         tTh   = threshT'($urandom % 34);
         hostWrite(`ADDR_A_MMASK, 4'hF, {16'd0, aMask});
         hostWrite(`ADDR_T_MMASK, 4'hF, tMask);
         hostWrite(`ADDR_A_THRESH, 4'hF, {24'd0, aTh});
         hostWrite(`ADDR_T_THRESH, 4'hF, {24'd0, tTh});
         driveInputs(a, t);
         // pipeline settles
         waitCycles(5);
         sumA = $countones(a & aMask);
         sumT = $countones(t & tMask);
         hostRead(`RES_SUM_A, rd);
         checkWord("mult sum A", wordT'(sumA), rd);
         hostRead(`RES_SUM_T, rd);
         checkWord("mult sum T", wordT'(sumT), rd);
         hostRead(`RES_COINC, rd);
         checkWord("mult flags", {20'd0, sumT >= tTh, 2'b00, sumA >= aTh, 8'd0},
                   rd & 32'h900);
      end
   endtask

   task automatic counterTest();
      int   pulses;
      int   clearCycle;
      int   sinceClear;
      wordT lo;
      wordT hi;
      wordT ticksFirst;
      wordT ticksSecond;
      driveInputs(frontA, '0);
      waitCycles(3);
      hostWrite(`ADDR_CLEAR, 4'h1, 32'h1);
      clearCycle = cycleCount;
      pulses = 1 + ($urandom % 8);
      // 3 cycles high and 3 low per pulse on line 7
      for (int i = 0; i < pulses; i++)
      begin
         trigIn[7] <= 1'b1;
         waitCycles(3);
         trigIn[7] <= 1'b0;
         waitCycles(3);
      end
      waitCycles(4);
      hostRead(`RES_NUMTRIG_LO, lo);
      hostRead(`RES_NUMTRIG_HI, hi);
      checkCount("counter numTrig", countT'(pulses), {hi, lo});
      hostRead(`RES_TICKS_LO, ticksFirst);
      sinceClear = cycleCount - clearCycle;
      if (ticksFirst >= wordT'(sinceClear))
      begin
         otherErrors++;
         $display("first tick read %0d is not below %0d cycles since clear",
                  ticksFirst, sinceClear);
      end
      waitCycles(10);
      hostRead(`RES_TICKS_LO, ticksSecond);
      sinceClear = cycleCount - clearCycle;
      if (ticksSecond <= ticksFirst)
      begin
         otherErrors++;
         $display("tick counter did not advance: %0d then %0d", ticksFirst, ticksSecond);
      end
      if (ticksSecond >= wordT'(sinceClear))
      begin
         otherErrors++;
         $display("second tick read %0d is not below %0d cycles since clear",
                  ticksSecond, sinceClear);
      end
   endtask

   task automatic outMuxTest();
      outSelT  codes [6];
      outSelT  code;
      trigBusT t;
      frontT   expOut;
      wordT    rd;
      logic    hit;
      codes = '{`OUTSEL_PASS, `OUTSEL_CMASK, `OUTSEL_MMASK, `OUTSEL_COINC, `OUTSEL_MULT,
                8'd7};
      // every code once with both flags set and once with both clear
      for (int i = 0; i < 12; i++)
      begin
         code = codes[i % 6];
         hit  = (i < 6);
         t    = $urandom;
         hostWrite(`ADDR_T_CMASK, 4'hF, $urandom);
         hostWrite(`ADDR_T_MMASK, 4'hF, $urandom);
         // pattern equal to the masked bus or to its complement
         hostWrite(`ADDR_T_CPAT, 4'hF,
                   hit ? (t & shadow[`ADDR_T_CMASK]) : ~(t & shadow[`ADDR_T_CMASK]));
         // threshold at the masked sum or one above it
         hostWrite(`ADDR_T_THRESH, 4'hF,
                   $countones(t & shadow[`ADDR_T_MMASK]) + (hit ? 0 : 1));
         hostWrite(`ADDR_B_OUTSEL, 4'hF, {24'd0, code});
         driveInputs(frontA, t);
         waitCycles(5);
         @(negedge proc_clk);
         case (code)
            `OUTSEL_PASS:  expOut = t[31:16];
            `OUTSEL_CMASK: expOut = t[31:16] & shadow[`ADDR_T_CMASK][31:16];
            `OUTSEL_MMASK: expOut = t[31:16] & shadow[`ADDR_T_MMASK][31:16];
            `OUTSEL_COINC: expOut = {16{(t & shadow[`ADDR_T_CMASK]) == shadow[`ADDR_T_CPAT]}};
            `OUTSEL_MULT:  expOut = {16{$countones(t & shadow[`ADDR_T_MMASK])
                                        >= shadow[`ADDR_T_THRESH][7:0]}};
            default:       expOut = '0;
         endcase
         checkFront("out mux", expOut, frontBOut);
      end
      // tick source against tick reads in the same window
      hostWrite(`ADDR_B_OUTSEL, 4'hF, {24'd0, `OUTSEL_TICK});
      waitCycles(5);
      hostRead(`RES_TICKS_LO, rd);
      checkFront("out mux tick", {16{rd[`TICK_BIT]}}, frontBOut);
      // 256 more ticks flip the tick bit
      waitCycles(254);
      hostRead(`RES_TICKS_LO, rd);
      checkFront("out mux tick flipped", {16{rd[`TICK_BIT]}}, frontBOut);
   endtask

   // *************************************************************************
   // run control
   // *************************************************************************
   initial
   begin
      repeat (watchdogCycles) @(posedge proc_clk);
      $display("timeout: tests did not finish within %0d cycles", watchdogCycles);
      $display("CHECKS FAILED");
      $finish;
   end

   initial
   begin
      void'($urandom(32'hdafa_6592));
      hostAddr   <= '0;
      hostWrStrb <= '0;
      hostWrData <= '0;
      hostRdEn   <= 1'b0;
      frontA     <= '0;
      trigIn     <= '0;
      wait (rstN === 1'b1);
      @(posedge proc_clk);
      // identity runs first because it needs the reset state
      identityTest();
      cfgReadbackTest();
      coincTest(40);
      multTest(40);
      counterTest();
      outMuxTest();
      waitCycles(2);
      $display("summary: %0d mismatches, %0d other errors", mismatchCount, otherErrors);
      if (mismatchCount == 0 && otherErrors == 0)
      begin
         $display("ALL CHECKS PASSED");
      end
      else
      begin
         $display("CHECKS FAILED");
      end
      $finish;
   end

endmodule
